/* hw/MazePkg.sv */
`default_nettype none

package MazePkg;

    localparam int MapRows = 10;
    localparam int MapCols = 20;
    localparam int RowWidth = 4;
    localparam int ColWidth = 5;
    localparam int LifeWidth = 4;

    typedef enum logic [0:0] {
        cellFree,
        cellWall
    } CellKind;

    // One bit per cell with column 0 leftmost and set bits as walls
    localparam logic [0:MapRows-1][0:MapCols-1] MazeMap = {
        20'b11111111111111111111,
        20'b10001000000000001111,
        20'b10101010111111101111,
        20'b10101010000000000001,
        20'b10101010111111101111,
        20'b10100010111111101111,
        20'b10101110111111101111,
        20'b10101110111111101111,
        20'b10101110111111101111,
        20'b10000000000000001111
    };

    typedef struct packed {
        logic [RowWidth-1:0] row;
        logic [ColWidth-1:0] col;
    } MazePos;

    typedef enum logic [1:0] {
        headNorth,
        headSouth,
        headEast,
        headWest
    } Heading;

    typedef struct packed {
        logic   present;
        MazePos pos;
    } DebrisSlot;

    // Also the slot index
    typedef enum logic [1:0] {
        debrisLight,
        debrisMedium,
        debrisHeavy
    } DebrisKind;

    // Removal steps for light, medium and heavy
    localparam logic [0:2][LifeWidth-1:0] DebrisLife = {4'd3, 4'd6, 4'd9};

    localparam MazePos CursorReset = '{row: 4'd5, col: 5'd10};
    localparam MazePos RobotReset = '{row: 4'd3, col: 5'd18};
    localparam MazePos BlackReset = '{row: 4'd3, col: 5'd18};
    localparam Heading HeadingReset = headEast;

    localparam DebrisSlot [0:2] DebrisReset = '{
        '{present: 1'b0, pos: '{row: 4'd0, col: 5'd0}},
        '{present: 1'b1, pos: '{row: 4'd5, col: 5'd15}},
        '{present: 1'b1, pos: '{row: 4'd3, col: 5'd17}}
    };

    // Anything off the map reads as wall
    function automatic CellKind cellAt(input MazePos p);
        if (p.row >= MapRows || p.col >= MapCols) begin
            return cellWall;
        end
        return CellKind'(MazeMap[p.row][p.col]);
    endfunction

    // Off-edge neighbors wrap to out-of-range rows or columns
    function automatic MazePos stepPos(input MazePos p, input Heading h);
        MazePos next;
        next = p;
        case (h)
            headNorth: next.row = p.row - 1'b1;
            headSouth: next.row = p.row + 1'b1;
            headEast:  next.col = p.col + 1'b1;
            default:   next.col = p.col - 1'b1;
        endcase
        return next;
    endfunction

    function automatic Heading turnLeft(input Heading h);
        case (h)
            headNorth: return headWest;
            headWest:  return headSouth;
            headSouth: return headEast;
            default:   return headNorth;
        endcase
    endfunction

endpackage

`default_nettype wire

/* hw/ControlPkg.sv */
`default_nettype none

package ControlPkg;
    import MazePkg::*;

    typedef enum logic [3:0] {
        padUp    = 4'd0,
        padDown  = 4'd1,
        padLeft  = 4'd2,
        padRight = 4'd3,
        padA     = 4'd4,
        padB     = 4'd5,
        padC     = 4'd6
    } GamepadBit;

    localparam int PadWidth = 12;

    // Periods in frames
    localparam int ReadPeriod = 5;
    localparam int StepPeriod = 9;

    typedef struct packed {
        logic head;
        logic left;
        logic under;
        logic barrier;
    } Sensors;

    typedef struct packed {
        MazePos          blackCell;
        DebrisSlot [0:2] debris;
        MazePos          robotPos;
        Heading          robotHeading;
        MazePos          cursor;
    } SpritePositions;

    typedef struct packed {
        logic      valid;
        DebrisKind kind;
    } FacedDebris;

    // First present slot at p with light checked first
    function automatic FacedDebris findDebris(input DebrisSlot [0:2] debris, input MazePos p);
        FacedDebris found;
        found = '{valid: 1'b0, kind: debrisLight};
        for (int k = 2; k >= 0; k--) begin
            if (debris[k].present && debris[k].pos == p) begin
                found = '{valid: 1'b1, kind: DebrisKind'(k)};
            end
        end
        return found;
    endfunction

endpackage

`default_nettype wire

/* hw/FramePacer.sv */
`default_nettype none

module FramePacer
    import ControlPkg::*;
(
    input  logic Clock50,
    input  logic reset,
    input  logic vSync,
    output logic readStrobe,
    output logic stepStrobe
);

    logic                          vSyncMeta;
    logic                          vSyncSync;
    logic                          vSyncLast;
    logic                          frameTick;
    logic [$clog2(ReadPeriod)-1:0] readCount;
    logic [$clog2(StepPeriod)-1:0] stepCount;

    // Preset high so a vSync already high at reset is not taken as an edge
    always_ff @(posedge Clock50) begin
        if (reset) begin
            vSyncMeta <= 1'b1;
            vSyncSync <= 1'b1;
            vSyncLast <= 1'b1;
        end else begin
            vSyncMeta <= vSync;
            vSyncSync <= vSyncMeta;
            vSyncLast <= vSyncSync;
        end
    end

    assign frameTick = vSyncSync && !vSyncLast;

    always_ff @(posedge Clock50) begin
        if (reset) begin
            readCount <= '0;
            stepCount <= '0;
        end else if (frameTick) begin
            readCount <= (readCount == ReadPeriod - 1) ? '0 : readCount + 1'b1;
            stepCount <= (stepCount == StepPeriod - 1) ? '0 : stepCount + 1'b1;
        end
    end

    // Read on ticks 1, 6, 11 and step on ticks 9, 18, 27
    assign readStrobe = frameTick && readCount == '0;
    assign stepStrobe = frameTick && stepCount == StepPeriod - 1;

endmodule

`default_nettype wire

/* hw/MapEditor.sv */
`default_nettype none

module MapEditor
    import MazePkg::*;
    import ControlPkg::*;
(
    input  logic                Clock50,
    input  logic                reset,
    input  logic                readStrobe,
    input  logic [PadWidth-1:0] gamepad,
    input  DebrisSlot [0:2]     debris,
    output MazePos              cursor,
    output MazePos              blackCell,
    output logic                placeRobot,
    output FacedDebris          clearKind
);

    logic       cursorFree;
    MazePos     cursorNext;
    FacedDebris cursorDebris;

    assign cursorFree = cellAt(cursor) == cellFree;
    assign cursorDebris = findDebris(debris, cursor);

    // Wrapping cursor moves
    always_comb begin
        cursorNext = cursor;
        if (gamepad[padUp]) begin
            cursorNext.row = (cursor.row == 0) ? RowWidth'(MapRows - 1) : cursor.row - 1'b1;
        end else if (gamepad[padDown]) begin
            cursorNext.row = (cursor.row == MapRows - 1) ? '0 : cursor.row + 1'b1;
        end
        if (gamepad[padLeft]) begin
            cursorNext.col = (cursor.col == 0) ? ColWidth'(MapCols - 1) : cursor.col - 1'b1;
        end else if (gamepad[padRight]) begin
            cursorNext.col = (cursor.col == MapCols - 1) ? '0 : cursor.col + 1'b1;
        end
    end

    // Pulses sit in the read cycle and use the cursor before it moves
    assign placeRobot = readStrobe && gamepad[padA] && cursorFree;
    assign clearKind = '{
        valid: readStrobe && gamepad[padC] && cursorDebris.valid,
        kind: cursorDebris.kind
    };

    always_ff @(posedge Clock50) begin
        if (reset) begin
            cursor <= CursorReset;
            blackCell <= BlackReset;
        end else if (readStrobe) begin
            cursor <= cursorNext;
            if (gamepad[padB] && cursorFree) begin
                blackCell <= cursor;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/RobotMotion.sv */
`default_nettype none

module RobotMotion
    import MazePkg::*;
    import ControlPkg::*;
(
    input  logic   Clock50,
    input  logic   reset,
    input  logic   stepStrobe,
    input  logic   placeRobot,
    input  MazePos cursor,
    input  Sensors sensors,
    input  logic   avancar,
    input  logic   girar,
    output MazePos robotPos,
    output Heading robotHeading
);

    MazePos ahead;

    assign ahead = stepPos(robotPos, robotHeading);

    always_ff @(posedge Clock50) begin
        if (reset) begin
            robotPos <= RobotReset;
            robotHeading <= HeadingReset;
        end else if (placeRobot) begin
            // Editor placement wins over a step in the same cycle
            robotPos <= cursor;
        end else if (stepStrobe) begin
            if (avancar) begin
                // Refused when facing the edge, a wall or debris
                if (!sensors.head && !sensors.barrier) begin
                    robotPos <= ahead;
                end
            end else if (girar) begin
                robotHeading <= turnLeft(robotHeading);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/SensorUnit.sv */
`default_nettype none

module SensorUnit
    import MazePkg::*;
    import ControlPkg::*;
(
    input  logic            Clock50,
    input  logic            reset,
    input  MazePos          robotPos,
    input  Heading          robotHeading,
    input  MazePos          blackCell,
    input  DebrisSlot [0:2] debris,
    output Sensors          sensors,
    output FacedDebris      faced
);

    MazePos ahead;
    MazePos leftCell;

    assign ahead = stepPos(robotPos, robotHeading);

    // Left side is one step along the heading turned left
    assign leftCell = stepPos(robotPos, turnLeft(robotHeading));

    // Debris slot directly ahead
    assign faced = findDebris(debris, ahead);

    always_ff @(posedge Clock50) begin
        if (reset) begin
            sensors <= '0;
        end else begin
            sensors.head <= cellAt(ahead) == cellWall;
            sensors.left <= cellAt(leftCell) == cellWall;
            sensors.under <= robotPos == blackCell;
            sensors.barrier <= faced.valid;
        end
    end

endmodule

`default_nettype wire

/* hw/DebrisField.sv */
`default_nettype none

module DebrisField
    import MazePkg::*;
    import ControlPkg::*;
(
    input  logic            Clock50,
    input  logic            reset,
    input  logic            stepStrobe,
    input  logic            remover,
    input  FacedDebris      faced,
    input  FacedDebris      clearKind,
    output DebrisSlot [0:2] debris
);

    logic [LifeWidth-1:0] lifeCount;
    logic                 removing;
    logic                 removeDone;

    assign removing = stepStrobe && remover && faced.valid;

    // The step that takes the count from one to zero
    assign removeDone = removing && lifeCount == LifeWidth'(1);

    always_ff @(posedge Clock50) begin
        if (reset) begin
            lifeCount <= '0;
        end else if (removing) begin
            if (lifeCount == '0) begin
                lifeCount <= DebrisLife[faced.kind] - 1'b1;
            end else begin
                lifeCount <= lifeCount - 1'b1;
            end
        end else if (stepStrobe) begin
            // Any interrupted removal starts over
            lifeCount <= '0;
        end
    end

    always_ff @(posedge Clock50) begin
        if (reset) begin
            debris <= DebrisReset;
        end else begin
            if (removeDone) begin
                debris[faced.kind].present <= 1'b0;
            end
            if (clearKind.valid) begin
                debris[clearKind.kind].present <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/RobotMazeTop.sv */
`default_nettype none

module RobotMazeTop
    import MazePkg::*;
    import ControlPkg::*;
(
    input  logic                Clock50,
    input  logic                reset,
    input  logic                vSync,
    input  logic [PadWidth-1:0] gamepad,
    input  logic                avancar,
    input  logic                girar,
    input  logic                remover,
    output Sensors              sensors,
    output SpritePositions      sprites
);

    logic            readStrobe;
    logic            stepStrobe;
    MazePos          cursor;
    MazePos          blackCell;
    logic            placeRobot;
    FacedDebris      clearKind;
    FacedDebris      faced;
    DebrisSlot [0:2] debris;
    MazePos          robotPos;
    Heading          robotHeading;

    FramePacer pacer (
        .Clock50    (Clock50),
        .reset      (reset),
        .vSync      (vSync),
        .readStrobe (readStrobe),
        .stepStrobe (stepStrobe)
    );

    MapEditor editor (
        .Clock50    (Clock50),
        .reset      (reset),
        .readStrobe (readStrobe),
        .gamepad    (gamepad),
        .debris     (debris),
        .cursor     (cursor),
        .blackCell  (blackCell),
        .placeRobot (placeRobot),
        .clearKind  (clearKind)
    );

    RobotMotion motion (
        .Clock50      (Clock50),
        .reset        (reset),
        .stepStrobe   (stepStrobe),
        .placeRobot   (placeRobot),
        .cursor       (cursor),
        .sensors      (sensors),
        .avancar      (avancar),
        .girar        (girar),
        .robotPos     (robotPos),
        .robotHeading (robotHeading)
    );

    SensorUnit sensing (
        .Clock50      (Clock50),
        .reset        (reset),
        .robotPos     (robotPos),
        .robotHeading (robotHeading),
        .blackCell    (blackCell),
        .debris       (debris),
        .sensors      (sensors),
        .faced        (faced)
    );

    DebrisField field (
        .Clock50    (Clock50),
        .reset      (reset),
        .stepStrobe (stepStrobe),
        .remover    (remover),
        .faced      (faced),
        .clearKind  (clearKind),
        .debris     (debris)
    );

    // Display gets the raw cell positions
    assign sprites = '{
        blackCell: blackCell,
        debris: debris,
        robotPos: robotPos,
        robotHeading: robotHeading,
        cursor: cursor
    };

endmodule

`default_nettype wire

/* test/MazeModel.svh */
`ifndef MAZE_MODEL_SVH
`define MAZE_MODEL_SVH

// Map rows with column 0 in the top bit and walls as set bits
localparam logic [19:0] WallRows [10] = '{
    20'b11111111111111111111,
    20'b10001000000000001111,
    20'b10101010111111101111,
    20'b10101010000000000001,
    20'b10101010111111101111,
    20'b10100010111111101111,
    20'b10101110111111101111,
    20'b10101110111111101111,
    20'b10101110111111101111,
    20'b10000000000000001111
};

function automatic bit wallAt(input int r, input int c);
    if (r < 0 || r >= 10 || c < 0 || c >= 20) begin
        return 1'b1;
    end
    return WallRows[r][19 - c];
endfunction

function automatic int rowDelta(input Heading h);
    if (h == headNorth) begin
        return -1;
    end
    return (h == headSouth) ? 1 : 0;
endfunction

function automatic int colDelta(input Heading h);
    if (h == headEast) begin
        return 1;
    end
    return (h == headWest) ? -1 : 0;
endfunction

// Heading a quarter turn counterclockwise
function automatic Heading leftOf(input Heading h);
    case (h)
        headNorth: return headWest;
        headWest:  return headSouth;
        headSouth: return headEast;
        default:   return headNorth;
    endcase
endfunction

function automatic Sensors modelSensors(input SpritePositions sp);
    int     r;
    int     c;
    int     ar;
    int     ac;
    Heading h;
    Sensors s;
    r = sp.robotPos.row;
    c = sp.robotPos.col;
    h = sp.robotHeading;
    ar = r + rowDelta(h);
    ac = c + colDelta(h);
    s.head = wallAt(ar, ac);
    s.left = wallAt(r + rowDelta(leftOf(h)), c + colDelta(leftOf(h)));
    s.under = sp.robotPos == sp.blackCell;
    s.barrier = 1'b0;
    for (int k = 0; k < 3; k++) begin
        if (sp.debris[k].present && sp.debris[k].pos.row == ar && sp.debris[k].pos.col == ac) begin
            s.barrier = 1'b1;
        end
    end
    return s;
endfunction

// Up beats Down and Left beats Right
function automatic MazePos moveCursor(input MazePos p, input logic [6:0] pad);
    int r;
    int c;
    r = p.row;
    c = p.col;
    if (pad[0]) begin
        r = (r + 9) % 10;
    end else if (pad[1]) begin
        r = (r + 1) % 10;
    end
    if (pad[2]) begin
        c = (c + 19) % 20;
    end else if (pad[3]) begin
        c = (c + 1) % 20;
    end
    return '{row: 4'(r), col: 5'(c)};
endfunction

// Ticks count from 1
function automatic bit isReadTick(input int n);
    return (n % 5) == 1;
endfunction

function automatic bit isStepTick(input int n);
    return n > 0 && (n % 9) == 0;
endfunction

`endif

/* test/RobotMazeTb.sv */
`default_nettype none

module RobotMazeTb
    import MazePkg::*;
    import ControlPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    `include "MazeModel.svh"

    localparam int RandomFrames = 60;
    // Ticks taken by the directed phase
    localparam int DirectedFrames = 306;
    localparam int PlannedFrames = DirectedFrames + RandomFrames;
    localparam int TimeoutCycles = PlannedFrames * 10 + 400;

    logic                Clock50;
    logic                reset;
    logic                vSync;
    logic [PadWidth-1:0] gamepad;
    logic                avancar;
    logic                girar;
    logic                remover;
    Sensors              sensors;
    SpritePositions      sprites;

    int             tickCount;
    int             cycleCount;
    MazePos         expCursor;
    logic [15:0]    lfsrState;
    SpritePositions prevSprites;
    logic           prevValid;

    RobotMazeTop uut (
        .Clock50 (Clock50),
        .reset   (reset),
        .vSync   (vSync),
        .gamepad (gamepad),
        .avancar (avancar),
        .girar   (girar),
        .remover (remover),
        .sensors (sensors),
        .sprites (sprites)
    );

    initial begin
        Clock50 = 1'b0;
        forever #2 Clock50 = ~Clock50;
    end

    task automatic failNow(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(
        input string                             name,
        input logic [$bits(SpritePositions)-1:0] got,
        input logic [$bits(SpritePositions)-1:0] exp
    );
        assert (got === exp)
            else failNow($sformatf("[ERROR] %s is 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    function automatic MazePos cellPos(input int r, input int c);
        return '{row: 4'(r), col: 5'(c)};
    endfunction

    function automatic SpritePositions resetSprites();
        SpritePositions s;
        s.blackCell = cellPos(3, 18);
        s.debris[0] = '{present: 1'b0, pos: cellPos(0, 0)};
        s.debris[1] = '{present: 1'b1, pos: cellPos(5, 15)};
        s.debris[2] = '{present: 1'b1, pos: cellPos(3, 17)};
        s.robotPos = cellPos(3, 18);
        s.robotHeading = headEast;
        s.cursor = cellPos(5, 10);
        return s;
    endfunction

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic takeBit();
        logic feedback;
        feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [6:0] takePad();
        logic [6:0] pad;
        for (int i = 0; i < 7; i++) begin
            pad[i] = takeBit();
        end
        return pad;
    endfunction

    // One 10-cycle frame with levels set while vSync is low
    task automatic runFrame(input logic [6:0] pad, input logic av, input logic gi, input logic rm);
        tickCount = tickCount + 1;
        if (isReadTick(tickCount)) begin
            expCursor = moveCursor(expCursor, pad);
        end
        @(posedge Clock50);
        gamepad <= {5'b0, pad};
        avancar <= av;
        girar <= gi;
        remover <= rm;
        repeat (2) @(posedge Clock50);
        vSync <= 1'b1;
        repeat (5) @(posedge Clock50);
        vSync <= 1'b0;
        repeat (2) @(posedge Clock50);
        checkValue("cursor", sprites.cursor, expCursor);
    endtask

    task automatic readFrame(input logic [6:0] pad);
        while (!isReadTick(tickCount + 1)) begin
            runFrame(7'b0, 1'b0, 1'b0, 1'b0);
        end
        runFrame(pad, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic stepFrame(input logic av, input logic gi, input logic rm);
        while (!isStepTick(tickCount + 1)) begin
            runFrame(7'b0, 1'b0, 1'b0, 1'b0);
        end
        runFrame(7'b0, av, gi, rm);
    endtask

    // Shortest way without wrapping
    task automatic moveCursorTo(input int r, input int c);
        logic [6:0] pad;
        while (sprites.cursor != cellPos(r, c)) begin
            pad = '0;
            if (sprites.cursor.row < r) begin
                pad[1] = 1'b1;
            end else if (sprites.cursor.row > r) begin
                pad[0] = 1'b1;
            end
            if (sprites.cursor.col < c) begin
                pad[3] = 1'b1;
            end else if (sprites.cursor.col > c) begin
                pad[2] = 1'b1;
            end
            readFrame(pad);
        end
    endtask

    // Sensors follow the previous cycle's sprites
    always @(posedge Clock50) begin
        if (prevValid) begin
            assert (sensors === modelSensors(prevSprites))
                else failNow($sformatf("[ERROR] sensors is 0x%0h, expected 0x%0h",
                    sensors, modelSensors(prevSprites)));
        end
        prevSprites <= sprites;
        prevValid <= !reset;
    end

    cursorOnMap: assert property (@(posedge Clock50) disable iff (reset)
        sprites.cursor.row < 4'd10 && sprites.cursor.col < 5'd20)
        else failNow("The cursor left the map");

    always @(posedge Clock50) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > TimeoutCycles) begin
            failNow("Timeout: the run went past its cycle limit");
        end
    end

    initial begin
        reset = 1'b1;
        vSync = 1'b0;
        gamepad = '0;
        avancar = 1'b0;
        girar = 1'b0;
        remover = 1'b0;
        tickCount = 0;
        cycleCount = 0;
        prevValid = 1'b0;
        expCursor = cellPos(5, 10);
        lfsrState = 16'd88;
        repeat (5) @(posedge Clock50);
        reset <= 1'b0;
        @(posedge Clock50);
        checkValue("sprites", sprites, resetSprites());
        repeat (2) @(posedge Clock50);
        checkValue("sensors", sensors, 4'b1110);

        // Tick 1 reads, tick 2 does not
        runFrame(7'b0000001, 1'b0, 1'b0, 1'b0);
        runFrame(7'b0000100, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < 10; i++) begin
            readFrame(i < 5 ? 7'b0001001 : 7'b0001000);
        end
        checkValue("cursor", sprites.cursor, cellPos(9, 0));

        // Placement onto a wall is ignored
        readFrame(7'b0010000);
        checkValue("robotPos", sprites.robotPos, cellPos(3, 18));
        readFrame(7'b0100000);
        checkValue("blackCell", sprites.blackCell, cellPos(3, 18));
        moveCursorTo(9, 1);
        readFrame(7'b0100000);
        checkValue("blackCell", sprites.blackCell, cellPos(9, 1));

        stepFrame(1'b1, 1'b0, 1'b0);
        checkValue("robotPos", sprites.robotPos, cellPos(3, 18));
        stepFrame(1'b0, 1'b1, 1'b0);
        checkValue("robotHeading", sprites.robotHeading, headNorth);
        stepFrame(1'b0, 1'b1, 1'b0);
        checkValue("robotHeading", sprites.robotHeading, headWest);
        // Heavy debris ahead blocks the advance
        stepFrame(1'b1, 1'b0, 1'b0);
        checkValue("robotPos", sprites.robotPos, cellPos(3, 18));

        moveCursorTo(3, 17);
        readFrame(7'b1000000);
        checkValue("debris[2].present", sprites.debris[2].present, 1'b0);
        stepFrame(1'b1, 1'b0, 1'b0);
        checkValue("robotPos", sprites.robotPos, cellPos(3, 17));

        moveCursorTo(4, 15);
        readFrame(7'b0010000);
        checkValue("robotPos", sprites.robotPos, cellPos(4, 15));
        stepFrame(1'b0, 1'b1, 1'b0);
        checkValue("robotHeading", sprites.robotHeading, headSouth);

        // Three removal steps, a break, then a full count of six
        repeat (3) stepFrame(1'b0, 1'b0, 1'b1);
        stepFrame(1'b0, 1'b0, 1'b0);
        for (int i = 1; i <= 6; i++) begin
            stepFrame(1'b0, 1'b0, 1'b1);
            checkValue("debris[1].present", sprites.debris[1].present, i < 6);
        end
        stepFrame(1'b1, 1'b0, 1'b0);
        checkValue("robotPos", sprites.robotPos, cellPos(5, 15));

        repeat (RandomFrames) begin
            runFrame(takePad(), takeBit(), takeBit(), takeBit());
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+test
hw/MazePkg.sv
hw/ControlPkg.sv
hw/FramePacer.sv
hw/MapEditor.sv
hw/RobotMotion.sv
hw/SensorUnit.sv
hw/DebrisField.sv
hw/RobotMazeTop.sv
test/RobotMazeTb.sv

/* Makefile */
SOURCES := $(wildcard hw/*.sv test/*.sv test/*.svh)

.PHONY: compile run clean

compile: obj_dir/VRobotMazeTb

obj_dir/VRobotMazeTb: all.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module RobotMazeTb -o VRobotMazeTb

run: compile
	./obj_dir/VRobotMazeTb

clean:
	rm -rf obj_dir
